// File: hw/dcache_pkg.sv
// data cache package
// geometry constants, address and frame layouts
// datapath and bus request/response structs, controller states
package dcache_pkg;

	typedef logic [31:0] word_t;

	localparam int NUM_WAYS = 2;
	localparam int NUM_SETS = 8;
	localparam int TAG_W    = 26;
	localparam int IDX_W    = 3;

	// byte address as seen by the cache
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic             blk;  // word within block
		logic [1:0]       bofs; // byte offset, ignored
	} dcache_addr_t;

	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
		word_t [1:0]      data; // indexed by blk
	} frame_t;

	typedef struct packed {
		logic  ren;
		logic  wen;
		logic  halt;
		word_t addr;
		word_t store;
	} dp_req_t;

	typedef struct packed {
		logic  hit;
		logic  flushed;
		word_t load;
	} dp_rsp_t;

	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	typedef struct packed {
		logic  dwait;
		word_t load;
	} mem_rsp_t;

	typedef struct packed {
		logic             hit;
		logic             hit_way;
		logic             victim_way;
		logic             victim_valid;
		logic             victim_dirty;
		logic [TAG_W-1:0] victim_tag;
		word_t            hit_word;
	} lookup_t;

	typedef struct packed {
		logic             en;
		logic             way;
		logic [IDX_W-1:0] idx;
		frame_t           frame;
	} frame_wr_t;

	typedef enum logic [2:0] {
		IDLE, ALLOCATE1, ALLOCATE2, WBACK1, WBACK2, FLUSH1, FLUSH2, END_FLUSH
	} ctrl_state_t;

endpackage

// File: hw/dcache_frame_array.sv
// frame storage for the data cache
// two ways by eight sets, combinational read, edge write
// one lru bit per set naming the next victim way
`timescale 1ns/1ps

module dcache_frame_array import dcache_pkg::*; (
	input  logic                          CLK,
	input  logic                          nRST,
	input  logic [IDX_W-1:0]              rd_idx,
	output frame_t [NUM_WAYS-1:0]         set_frames,
	input  logic                          sel_way,
	output frame_t                        sel_frame,
	input  frame_wr_t                     wr,
	input  logic                          lru_set,
	input  logic                          lru_way,
	output logic [NUM_SETS-1:0]           lru
);

	frame_t frames [NUM_WAYS][NUM_SETS];

	// both ways of the addressed set go to the lookup
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			set_frames[w] = frames[w][rd_idx];
		end
	end

	assign sel_frame = frames[sel_way][rd_idx]; // one frame for the controller

	// frame writes, one frame per cycle at most
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					frames[w][s] <= '0; // every frame invalid and clean
				end
			end
		end else if (wr.en) begin
			frames[wr.way][wr.idx] <= wr.frame;
		end
	end

	// lru bit holds the way to evict next
	// a touch of lru_way makes the other way the victim
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
		end else if (lru_set) begin
			lru[rd_idx] <= ~lru_way;
		end
	end

endmodule

// File: hw/dcache_lookup.sv
// tag compare and hit word select for the addressed set
// victim choice from valid bits and the set's lru bit
`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; (
	input  word_t                 addr,
	input  frame_t [NUM_WAYS-1:0] set_frames,
	input  logic                  lru_bit,
	output lookup_t               res
);

	dcache_addr_t a;
	logic         match0;
	logic         match1;
	logic         vway;

	assign a = dcache_addr_t'(addr);

	assign match0 = set_frames[0].valid && (set_frames[0].tag == a.tag);
	assign match1 = set_frames[1].valid && (set_frames[1].tag == a.tag);

	// fill an empty way before evicting anything
	always_comb begin
		if (!set_frames[0].valid) begin
			vway = 1'b0;
		end else if (!set_frames[1].valid) begin
			vway = 1'b1;
		end else begin
			vway = lru_bit;
		end
	end

	always_comb begin
		res.hit          = match0 || match1;
		res.hit_way      = !match0;           // way 0 wins a double match
		res.hit_word     = set_frames[res.hit_way].data[a.blk];
		res.victim_way   = vway;
		res.victim_valid = set_frames[vway].valid;
		res.victim_dirty = set_frames[vway].dirty;
		res.victim_tag   = set_frames[vway].tag;
	end

endmodule

// File: hw/dcache_ctrl.sv
// data cache controller FSM
// same-cycle hits, dirty victim write-back, two-word allocation
// flush walk over all frames on halt
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
	input  logic             CLK,
	input  logic             nRST,
	input  dp_req_t          req,
	output dp_rsp_t          rsp,
	input  lookup_t          look,
	input  frame_t           sel_frame,
	output logic [IDX_W-1:0] rd_idx,
	output logic             sel_way,
	output frame_wr_t        wr,
	output logic             lru_set,
	output logic             lru_way,
	output mem_req_t         mreq,
	input  mem_rsp_t         mrsp
);

	ctrl_state_t  state, state_n;
	logic         vway, vway_n;             // latched victim way
	logic [4:0]   flush_cnt, flush_cnt_n;   // {set, way}, bit 4 marks done
	word_t        fill_word;                // blk 0 word of an allocation
	dcache_addr_t a;
	logic         flush_walk;

	assign a          = dcache_addr_t'(req.addr);
	assign flush_walk = (state == FLUSH1) || (state == FLUSH2);
	assign rd_idx     = flush_walk ? flush_cnt[3:1] : a.idx;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= IDLE;
			vway      <= 1'b0;
			flush_cnt <= '0;
		end else begin
			state     <= state_n;
			vway      <= vway_n;
			flush_cnt <= flush_cnt_n;
		end
	end

	// first allocation word waits here until the second arrives
	always_ff @(posedge CLK) begin
		if (state == ALLOCATE1 && !mrsp.dwait) begin
			fill_word <= mrsp.load;
		end
	end

	always_comb begin
		state_n     = state;
		vway_n      = vway;
		flush_cnt_n = flush_cnt;
		rsp         = '0;
		rsp.flushed = (state == END_FLUSH);
		sel_way     = flush_walk ? flush_cnt[0] : vway;
		wr          = '0;
		lru_set     = 1'b0;
		lru_way     = look.hit_way;
		mreq        = '0;

		case (state)
			IDLE: begin
				if (req.ren || req.wen) begin
					if (look.hit) begin
						rsp.hit  = 1'b1;
						rsp.load = look.hit_word;
						sel_way  = look.hit_way; // hit frame for the store merge
						lru_set  = 1'b1;
						if (req.wen) begin
							wr.en                   = 1'b1;
							wr.way                  = look.hit_way;
							wr.idx                  = a.idx;
							wr.frame                = sel_frame;
							wr.frame.dirty          = 1'b1;
							wr.frame.data[a.blk]    = req.store;
						end
					end else begin
						vway_n = look.victim_way;
						if (look.victim_valid && look.victim_dirty) begin
							state_n = WBACK1;
						end else begin
							state_n = ALLOCATE1;
						end
					end
				end else if (req.halt) begin
					flush_cnt_n = '0;
					state_n     = FLUSH1;
				end
			end

			WBACK1: begin
				mreq.wen   = 1'b1;
				mreq.addr  = {look.victim_tag, a.idx, 1'b0, 2'b00};
				mreq.store = sel_frame.data[0];
				if (!mrsp.dwait) begin
					state_n = WBACK2;
				end
			end

			WBACK2: begin
				mreq.wen   = 1'b1;
				mreq.addr  = {look.victim_tag, a.idx, 1'b1, 2'b00};
				mreq.store = sel_frame.data[1];
				if (!mrsp.dwait) begin
					state_n = ALLOCATE1;
				end
			end

			ALLOCATE1: begin
				mreq.ren  = 1'b1;
				mreq.addr = {a.tag, a.idx, 1'b0, 2'b00};
				if (!mrsp.dwait) begin
					state_n = ALLOCATE2;
				end
			end

			ALLOCATE2: begin
				mreq.ren  = 1'b1;
				mreq.addr = {a.tag, a.idx, 1'b1, 2'b00};
				if (!mrsp.dwait) begin
					wr.en            = 1'b1;
					wr.way           = vway;
					wr.idx           = a.idx;
					wr.frame.valid   = 1'b1;
					wr.frame.dirty   = 1'b0;
					wr.frame.tag     = a.tag;
					wr.frame.data[0] = fill_word;
					wr.frame.data[1] = mrsp.load;
					lru_set          = 1'b1;
					lru_way          = vway; // other way is next victim
					state_n          = IDLE;
				end
			end

			FLUSH1: begin
				if (flush_cnt[4]) begin
					state_n = END_FLUSH;
				end else if (sel_frame.valid && sel_frame.dirty) begin
					mreq.wen   = 1'b1;
					mreq.addr  = {sel_frame.tag, rd_idx, 1'b1, 2'b00};
					mreq.store = sel_frame.data[1];
					if (!mrsp.dwait) begin
						state_n = FLUSH2;
					end
				end else begin
					// clean frame, just drop it
					wr.en          = 1'b1;
					wr.way         = sel_way;
					wr.idx         = rd_idx;
					wr.frame       = sel_frame;
					wr.frame.valid = 1'b0;
					wr.frame.dirty = 1'b0;
					flush_cnt_n    = flush_cnt + 5'd1;
				end
			end

			FLUSH2: begin
				mreq.wen   = 1'b1;
				mreq.addr  = {sel_frame.tag, rd_idx, 1'b0, 2'b00};
				mreq.store = sel_frame.data[0];
				if (!mrsp.dwait) begin
					wr.en          = 1'b1;
					wr.way         = sel_way;
					wr.idx         = rd_idx;
					wr.frame       = sel_frame;
					wr.frame.valid = 1'b0;
					wr.frame.dirty = 1'b0;
					flush_cnt_n    = flush_cnt + 5'd1;
					state_n        = FLUSH1;
				end
			end

			END_FLUSH: begin
				state_n = END_FLUSH; // parked until reset
			end

			default: begin
				state_n = IDLE;
			end
		endcase
	end

endmodule

// File: hw/dcache.sv
// data cache top level
// frame array, lookup and controller instances
`timescale 1ns/1ps

module dcache import dcache_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  dp_req_t  dp_req,
	output dp_rsp_t  dp_rsp,
	output mem_req_t mem_req,
	input  mem_rsp_t mem_rsp
);

	frame_t [NUM_WAYS-1:0] set_frames;
	frame_t                sel_frame;
	lookup_t               look;
	frame_wr_t             wr;
	logic [IDX_W-1:0]      rd_idx;
	logic                  sel_way;
	logic                  lru_set;
	logic                  lru_way;
	logic [NUM_SETS-1:0]   lru;

	dcache_frame_array frame_array_i (
		.CLK        (CLK),
		.nRST       (nRST),
		.rd_idx     (rd_idx),
		.set_frames (set_frames),
		.sel_way    (sel_way),
		.sel_frame  (sel_frame),
		.wr         (wr),
		.lru_set    (lru_set),
		.lru_way    (lru_way),
		.lru        (lru)
	);

	// lru bit of the set being looked up
	dcache_lookup lookup_i (
		.addr       (dp_req.addr),
		.set_frames (set_frames),
		.lru_bit    (lru[rd_idx]),
		.res        (look)
	);

	dcache_ctrl ctrl_i (
		.CLK        (CLK),
		.nRST       (nRST),
		.req        (dp_req),
		.rsp        (dp_rsp),
		.look       (look),
		.sel_frame  (sel_frame),
		.rd_idx     (rd_idx),
		.sel_way    (sel_way),
		.wr         (wr),
		.lru_set    (lru_set),
		.lru_way    (lru_way),
		.mreq       (mem_req),
		.mrsp       (mem_rsp)
	);

endmodule

// File: tb/dcache_clk_gen.sv
// testbench clock and reset
// 100 ns clock, reset held low for three cycles
`timescale 1ns/1ps

module dcache_clk_gen (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		nRST = 1'b0;
		repeat (3) @(posedge CLK);
		nRST <= 1'b1; // released on the edge like any other input
	end

endmodule

// File: tb/dcache_mem_model.sv
// word-wide memory responder for the data cache bus
// 256-word array, 0 to 3 random wait cycles per transfer
`timescale 1ns/1ps

module dcache_mem_model import dcache_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	word_t      mem [256];
	logic [1:0] wait_cnt;   // wait cycles left for the current transfer
	logic       active;
	integer     seed = 69;

	assign active    = req.ren || req.wen;
	assign rsp.dwait = active && (wait_cnt != 2'd0);
	assign rsp.load  = mem[req.addr[9:2]];

	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= word_t'(i) ^ 32'h5A5A0000;
			end
			wait_cnt <= 2'($random(seed));
		end else if (active) begin
			if (wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end else begin
				// transfer completes on this edge
				if (req.wen) begin
					mem[req.addr[9:2]] <= req.store;
				end
				wait_cnt <= 2'($random(seed)); // stall for the next one
			end
		end
	end

endmodule

// File: tb/dcache_sva.sv
// concurrent checks on the data cache ports
// reset levels, hits without bus traffic, bus stability,
// allocation read order, refill hit and the flushed level
`timescale 1ns/1ps

module dcache_sva import dcache_pkg::*; (
	input logic        CLK,
	input logic        nRST,
	input dp_req_t     dp_req,
	input dp_rsp_t     dp_rsp,
	input mem_req_t    mem_req,
	input mem_rsp_t    mem_rsp,
	input ctrl_state_t state
);

	int fail_cnt = 0; // failed checks so far

	// outputs quiet once reset is gone
	a_reset_quiet: assert property (@(posedge CLK)
		$rose(nRST) |=> !mem_req.ren && !mem_req.wen && !dp_rsp.hit && !dp_rsp.flushed)
		else begin
			$error("outputs active right after reset");
			fail_cnt++;
		end

	a_hit_no_bus: assert property (@(posedge CLK) disable iff (!nRST)
		dp_rsp.hit |-> !(mem_req.ren || mem_req.wen))
		else begin
			$error("hit raised during a bus transfer");
			fail_cnt++;
		end

	a_bus_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen))
		else begin
			$error("bus read and write requested together");
			fail_cnt++;
		end

	// request held while the bus stalls
	a_bus_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_req.ren || mem_req.wen) && mem_rsp.dwait |=> $stable(mem_req))
		else begin
			$error("bus request changed under dwait");
			fail_cnt++;
		end

	a_alloc_block: assert property (@(posedge CLK) disable iff (!nRST)
		mem_req.ren |-> mem_req.addr[31:3] == dp_req.addr[31:3])
		else begin
			$error("allocation read outside the requested block");
			fail_cnt++;
		end

	// a read pair opens with blk 0
	a_alloc_first: assert property (@(posedge CLK) disable iff (!nRST)
		mem_req.ren && !$past(mem_req.ren) |-> !mem_req.addr[2])
		else begin
			$error("first allocation read is not blk 0");
			fail_cnt++;
		end

	// blk 1 read right after a completed blk 0 read
	a_alloc_second: assert property (@(posedge CLK) disable iff (!nRST)
		mem_req.ren && !mem_req.addr[2] && !mem_rsp.dwait |=>
			mem_req.ren && mem_req.addr[2])
		else begin
			$error("second allocation read out of order");
			fail_cnt++;
		end

	// held request hits once the block is filled
	a_refill_hit: assert property (@(posedge CLK) disable iff (!nRST)
		state == ALLOCATE2 && !mem_rsp.dwait |=> dp_rsp.hit)
		else begin
			$error("no hit in the cycle after the block was filled");
			fail_cnt++;
		end

	a_flushed_holds: assert property (@(posedge CLK) disable iff (!nRST)
		dp_rsp.flushed |=> dp_rsp.flushed)
		else begin
			$error("flushed dropped before reset");
			fail_cnt++;
		end

endmodule

// File: tb/dcache_tb.sv
// data cache testbench top
// random reads and writes over conflicting sets, then halt and flush
// shadow memory, error counts and the closing result
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

	logic     CLK;
	logic     nRST;
	dp_req_t  dp_req;
	dp_rsp_t  dp_rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	word_t    shadow [256];  // values written by the datapath
	logic     written [256];
	integer   seed = 69;
	int       mismatches = 0;
	int       timeouts = 0;
	int       sva_fails;

	dcache_clk_gen clk_gen_i (.CLK(CLK), .nRST(nRST));

	dcache dcache_i (
		.CLK     (CLK),
		.nRST    (nRST),
		.dp_req  (dp_req),
		.dp_rsp  (dp_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	dcache_mem_model mem_i (.CLK(CLK), .nRST(nRST), .req(mem_req), .rsp(mem_rsp));

	bind dcache dcache_sva sva_i (
		.CLK     (CLK),
		.nRST    (nRST),
		.dp_req  (dp_req),
		.dp_rsp  (dp_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp),
		.state   (ctrl_i.state)
	);

	// memory content before any write
	function automatic word_t init_pattern(input logic [7:0] w);
		return {24'h0, w} ^ 32'h5A5A0000;
	endfunction

	// one datapath access, held until hit
	task automatic access(input logic is_wr, input logic [5:0] r, output logic ok);
		logic [7:0] w;
		word_t      data;
		word_t      expected;
		int         cycles;
		w    = {r[5:2], r[1], 2'b00, r[0]}; // sets 0 and 4 only, 16 tags
		data = $random(seed);
		@(posedge CLK);
		dp_req.ren   <= !is_wr;
		dp_req.wen   <= is_wr;
		dp_req.addr  <= {22'h0, w, 2'b00};
		dp_req.store <= data;
		cycles = 0;
		@(negedge CLK);
		while (!dp_rsp.hit && cycles < 200) begin
			@(negedge CLK);
			cycles++;
		end
		ok = dp_rsp.hit;
		if (!ok) begin
			$display("Timeout waiting for hit on address %h", {22'h0, w, 2'b00});
			timeouts++;
		end else if (is_wr) begin
			shadow[w]  = data;
			written[w] = 1'b1;
		end else begin
			expected = written[w] ? shadow[w] : init_pattern(w);
			assert (dp_rsp.load === expected) else begin
				$display("Mismatch dp_rsp.load at %h: got %h, expected %h",
					{22'h0, w, 2'b00}, dp_rsp.load, expected);
				mismatches++;
			end
		end
	endtask

	initial begin : stimulus
		logic  ok;
		word_t pick;
		int    n;
		int    cycles;
		dp_req = '0;
		for (int i = 0; i < 256; i++) begin
			shadow[i]  = '0;
			written[i] = 1'b0;
		end
		ok = 1'b1;
		n  = 0;
		repeat (5) @(posedge CLK); // reset plus two idle cycles
		while (ok && n < 300) begin
			pick = $random(seed);
			access(pick[6], pick[5:0], ok);
			n++;
		end
		if (ok) begin
			@(posedge CLK);
			dp_req.ren  <= 1'b0;
			dp_req.wen  <= 1'b0;
			dp_req.halt <= 1'b1;
			cycles = 0;
			@(negedge CLK);
			while (!dp_rsp.flushed && cycles < 200) begin
				@(negedge CLK);
				cycles++;
			end
			if (!dp_rsp.flushed) begin
				$display("Timeout waiting for flushed after halt");
				timeouts++;
			end else begin
				// every dirty word must be back in memory
				for (int i = 0; i < 256; i++) begin
					if (written[i]) begin
						assert (mem_i.mem[i] === shadow[i]) else begin
							$display("Mismatch mem[%h]: got %h, expected %h",
								i[7:0], mem_i.mem[i], shadow[i]);
							mismatches++;
						end
					end
				end
				repeat (4) @(posedge CLK);
			end
		end
		sva_fails = dcache_i.sva_i.fail_cnt;
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, sva_fails);
		if (mismatches + timeouts + sva_fails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: tb.f
hw/dcache_pkg.sv
hw/dcache_frame_array.sv
hw/dcache_lookup.sv
hw/dcache_ctrl.sv
hw/dcache.sv
tb/dcache_clk_gen.sv
tb/dcache_mem_model.sv
tb/dcache_sva.sv
tb/dcache_tb.sv
